// ==== hdl/bpf_params.svh ====
`ifndef BPF_PARAMS_SVH
`define BPF_PARAMS_SVH

// Code memory depth is 2**BPF_CODE_AW instructions
`define BPF_CODE_AW 8

// Packet buffer, byte addressed, 2 KiB
`define BPF_PKT_AW 11

// Same buffer seen as 32-bit storage words
`define BPF_PKT_WAW 9

// One bit more than the byte address so a full buffer length fits
`define BPF_LEN_W 12

`endif

// ==== hdl/bpf_isa_pkg.sv ====
package bpf_isa_pkg;

	typedef struct packed {
		logic [15:0] opcode; // Classic BPF only uses the low byte
		logic [7:0]  jt; // Taken offset, relative to next insn
		logic [7:0]  jf; // Not-taken offset
		logic [31:0] k; // Immediate, address or jump offset
	} bpf_insn_t;

	typedef logic [31:0] pkt_word_t; // Byte 0 sits in bits 31:24

	localparam logic [2:0] CLS_LD   = 3'h0; // opcode[2:0]
	localparam logic [2:0] CLS_LDX  = 3'h1;
	localparam logic [2:0] CLS_ALU  = 3'h4;
	localparam logic [2:0] CLS_JMP  = 3'h5;
	localparam logic [2:0] CLS_RET  = 3'h6;
	localparam logic [2:0] CLS_MISC = 3'h7;

	localparam logic [1:0] SZ_W = 2'h0; // opcode[4:3]
	localparam logic [1:0] SZ_H = 2'h1;
	localparam logic [1:0] SZ_B = 2'h2;

	localparam logic [2:0] MODE_IMM = 3'h0; // opcode[7:5]
	localparam logic [2:0] MODE_ABS = 3'h1;
	localparam logic [2:0] MODE_IND = 3'h2;
	localparam logic [2:0] MODE_LEN = 3'h4;

	localparam logic SRC_K = 1'b0; // opcode[3], operand is k
	localparam logic SRC_X = 1'b1; // Operand is X

	localparam logic [3:0] ALU_ADD = 4'h0; // opcode[7:4]
	localparam logic [3:0] ALU_SUB = 4'h1;
	localparam logic [3:0] ALU_OR  = 4'h4;
	localparam logic [3:0] ALU_AND = 4'h5;
	localparam logic [3:0] ALU_LSH = 4'h6;
	localparam logic [3:0] ALU_RSH = 4'h7;

	localparam logic [3:0] JMP_JA   = 4'h0; // opcode[7:4]
	localparam logic [3:0] JMP_JEQ  = 4'h1;
	localparam logic [3:0] JMP_JGT  = 4'h2;
	localparam logic [3:0] JMP_JGE  = 4'h3;
	localparam logic [3:0] JMP_JSET = 4'h4;

	localparam logic [1:0] RVAL_K = 2'h0; // opcode[4:3] of RET
	localparam logic [1:0] RVAL_A = 2'h2;

	localparam logic MISC_TAX = 1'b0; // opcode[7] of MISC
	localparam logic MISC_TXA = 1'b1;

endpackage

// ==== hdl/bpf_core_pkg.sv ====
package bpf_core_pkg;

	typedef enum logic [2:0] {A_ALU, A_PKT, A_LEN, A_K, A_X} a_sel_e; // Next A source
	typedef enum logic [1:0] {X_K, X_LEN, X_A} x_sel_e; // Next X source
	typedef enum logic [1:0] {PC_INC, PC_K, PC_JT, PC_JF} pc_sel_e; // All relative to pc+1

	typedef struct packed {
		a_sel_e     a_sel;
		x_sel_e     x_sel;
		logic       a_en;
		logic       x_en;
		pc_sel_e    pc_sel;
		logic       pc_en;
		logic       b_sel; // 0 is k, 1 is X, same as the opcode src bit
		logic [3:0] alu_op; // ALU op field straight from the opcode
		logic       addr_ind; // Packet address is X plus k
		logic [1:0] load_size; // Size field of the load
		logic       pc_clr; // Start of a run, clears PC, A and X
	} ctrl_t;

	typedef struct packed {
		logic eq; // A == operand
		logic gt; // A > operand, unsigned
		logic ge; // A >= operand, unsigned
		logic set; // A & operand nonzero
		logic oob; // Current packet load reaches past packet_len
	} flags_t;

endpackage

// ==== hdl/bpf_mem.sv ====
`timescale 1ns/1ps

module bpf_mem #(
	parameter type word_t = logic [31:0], // Instruction or packet word
	parameter int  AW     = 8
) (
	input  logic          clk,
	input  logic          wr,
	input  logic [AW-1:0] wr_addr,
	input  word_t         wr_data,
	input  logic          rd_en,
	input  logic [AW-1:0] rd_addr,
	output word_t         rd_data
);

	word_t mem [2**AW]; // Plain array, maps onto block RAM

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_addr] <= wr_data; // Load port, driven from outside
		end
	end

	// Read port for the core, data valid one cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr]; // Holds last word when idle
		end
	end

endmodule

// ==== hdl/bpf_alu.sv ====
`timescale 1ns/1ps

module bpf_alu import bpf_isa_pkg::*, bpf_core_pkg::*; (
	input  logic [3:0]  op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] y,
	output flags_t      flags
);

	logic big_shift;

	assign big_shift = |b[31:5]; // Shift count of 32 or more

	always_comb begin
		case (op)
			ALU_ADD: y = a + b; // Wraps modulo 2**32
			ALU_SUB: y = a - b;
			ALU_OR:  y = a | b;
			ALU_AND: y = a & b;
			ALU_LSH: y = big_shift ? '0 : a << b[4:0];
			ALU_RSH: y = big_shift ? '0 : a >> b[4:0]; // Logical shift
			default: y = a; // Ops not built leave A unchanged
		endcase
	end

	// Jump tests share the operand mux with the ALU
	assign flags.eq  = (a == b);
	assign flags.gt  = (a > b); // Unsigned like BPF
	assign flags.ge  = (a >= b);
	assign flags.set = |(a & b); // jset
	assign flags.oob = 1'b0; // Bounds check lives in the datapath

endmodule

// ==== hdl/bpf_datapath.sv ====
`timescale 1ns/1ps
`include "bpf_params.svh"

module bpf_datapath import bpf_isa_pkg::*, bpf_core_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  ctrl_t                   ctrl,
	input  logic                    insn_ld,
	input  bpf_insn_t               code_q,
	input  pkt_word_t               pkt_q,
	input  logic [`BPF_LEN_W-1:0]   packet_len,
	output bpf_insn_t               insn,
	output logic [`BPF_CODE_AW-1:0] pc,
	output logic [`BPF_PKT_WAW-1:0] pkt_rd_addr,
	output flags_t                  flags,
	output logic [31:0]             a
);

	logic [31:0]             x;
	logic [31:0]             b; // Second ALU and compare operand
	logic [31:0]             alu_y;
	flags_t                  alu_flags;
	logic [2:0]              nbytes; // Bytes touched by the load
	logic [33:0]             byte_addr; // Two spare bits so X plus k cannot wrap
	logic [33:0]             byte_end;
	logic [1:0]              lane_q; // Byte offset within the word read last cycle
	logic [31:0]             pkt_val;
	logic [31:0]             a_next;
	logic [31:0]             x_next;
	logic [`BPF_CODE_AW-1:0] pc_inc;

	assign b = ctrl.b_sel ? x : insn.k;

	bpf_alu alu_i (
		.op    (ctrl.alu_op),
		.a     (a),
		.b     (b),
		.y     (alu_y),
		.flags (alu_flags)
	);

	always_comb begin
		case (ctrl.load_size)
			SZ_H:    nbytes = 3'd2;
			SZ_B:    nbytes = 3'd1;
			default: nbytes = 3'd4;
		endcase
	end

	assign byte_addr   = ctrl.addr_ind ? (34'(x) + 34'(insn.k)) : 34'(insn.k);
	assign byte_end    = byte_addr + 34'(nbytes); // One past the last byte
	assign pkt_rd_addr = byte_addr[`BPF_PKT_AW-1:2]; // Low bits pick the lane later

	always_comb begin
		flags     = alu_flags;
		flags.oob = (byte_end > 34'(packet_len)); // BPF rejects on short packet
	end

	always_ff @(posedge clk) begin
		lane_q <= byte_addr[1:0]; // Same cycle as the read is issued
	end

	// Big-endian lanes, unaligned bits are dropped
	always_comb begin
		case (ctrl.load_size)
			SZ_B:    pkt_val = 32'(pkt_q[8 * (3 - lane_q) +: 8]);
			SZ_H:    pkt_val = lane_q[1] ? 32'(pkt_q[15:0]) : 32'(pkt_q[31:16]);
			default: pkt_val = pkt_q;
		endcase
	end

	always_comb begin
		case (ctrl.a_sel)
			A_PKT:   a_next = pkt_val;
			A_LEN:   a_next = 32'(packet_len);
			A_K:     a_next = insn.k;
			A_X:     a_next = x; // TXA
			default: a_next = alu_y;
		endcase
		case (ctrl.x_sel)
			X_LEN:   x_next = 32'(packet_len);
			X_A:     x_next = a; // TAX
			default: x_next = insn.k;
		endcase
	end

	assign pc_inc = pc + 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			insn <= '0;
		end else if (insn_ld) begin
			insn <= code_q; // Decode cycle, code_q just arrived
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			a  <= '0;
			x  <= '0;
			pc <= '0;
		end else if (ctrl.pc_clr) begin
			a  <= '0; // Each run starts from clean registers
			x  <= '0;
			pc <= '0;
		end else begin
			if (ctrl.a_en) begin
				a <= a_next;
			end
			if (ctrl.x_en) begin
				x <= x_next;
			end
			if (ctrl.pc_en) begin
				case (ctrl.pc_sel)
					PC_K:    pc <= pc_inc + insn.k[`BPF_CODE_AW-1:0]; // ja
					PC_JT:   pc <= pc_inc + `BPF_CODE_AW'(insn.jt);
					PC_JF:   pc <= pc_inc + `BPF_CODE_AW'(insn.jf);
					default: pc <= pc_inc;
				endcase
			end
		end
	end

endmodule

// ==== hdl/bpf_ctrl.sv ====
`timescale 1ns/1ps

module bpf_ctrl import bpf_isa_pkg::*, bpf_core_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      start,
	input  bpf_insn_t insn,
	input  flags_t    flags,
	input  logic      a_zero, // A is zero, for RET A
	output ctrl_t     ctrl,
	output logic      insn_ld,
	output logic      code_rd_en,
	output logic      pkt_rd_en,
	output logic      busy,
	output logic      done,
	output logic      accept,
	output logic      ret_sel_a
);

	typedef enum logic [2:0] {S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_LOAD_WAIT, S_DONE} state_e;

	state_e     state;
	state_e     state_next;
	logic [2:0] cls;
	logic [2:0] mode;
	logic       jump_taken;
	logic       end_run; // RET, or a load past the packet end
	logic       accept_next;

	assign cls  = insn.opcode[2:0];
	assign mode = insn.opcode[7:5];

	always_comb begin
		case (insn.opcode[7:4])
			JMP_JEQ:  jump_taken = flags.eq;
			JMP_JGT:  jump_taken = flags.gt;
			JMP_JGE:  jump_taken = flags.ge;
			JMP_JSET: jump_taken = flags.set;
			default:  jump_taken = 1'b0;
		endcase
	end

	always_comb begin
		ctrl            = '0;
		ctrl.b_sel      = insn.opcode[3]; // SRC_K or SRC_X
		ctrl.alu_op     = insn.opcode[7:4];
		ctrl.addr_ind   = (mode == MODE_IND);
		ctrl.load_size  = insn.opcode[4:3]; // Bounds check needs it before the read
		state_next      = state;
		insn_ld         = 1'b0;
		code_rd_en      = 1'b0;
		pkt_rd_en       = 1'b0;
		end_run         = 1'b0;
		accept_next     = 1'b0;
		case (state)
			S_IDLE: begin
				if (start) begin
					ctrl.pc_clr = 1'b1;
					state_next  = S_FETCH;
				end
			end
			S_FETCH: begin
				code_rd_en = 1'b1; // Address is PC
				state_next = S_DECODE;
			end
			S_DECODE: begin
				insn_ld    = 1'b1;
				state_next = S_EXEC;
			end
			S_EXEC: begin
				state_next  = S_FETCH;
				ctrl.pc_en  = 1'b1; // Most instructions just step
				case (cls)
					CLS_LD: begin
						case (mode)
							MODE_IMM: begin
								ctrl.a_sel = A_K;
								ctrl.a_en  = 1'b1;
							end
							MODE_LEN: begin
								ctrl.a_sel = A_LEN;
								ctrl.a_en  = 1'b1;
							end
							MODE_ABS, MODE_IND: begin
								ctrl.pc_en = 1'b0; // Steps in the wait cycle
								if (flags.oob) begin
									end_run    = 1'b1; // Reject, no read issued
									state_next = S_DONE;
								end else begin
									pkt_rd_en  = 1'b1;
									state_next = S_LOAD_WAIT;
								end
							end
							default: ; // Scratch and MSH loads not built
						endcase
					end
					CLS_LDX: begin
						ctrl.x_en  = (mode == MODE_IMM) || (mode == MODE_LEN);
						ctrl.x_sel = (mode == MODE_LEN) ? X_LEN : X_K;
					end
					CLS_ALU: begin
						ctrl.a_sel = A_ALU;
						ctrl.a_en  = 1'b1;
					end
					CLS_JMP: begin
						if (insn.opcode[7:4] == JMP_JA) begin
							ctrl.pc_sel = PC_K;
						end else begin
							ctrl.pc_sel = jump_taken ? PC_JT : PC_JF;
						end
					end
					CLS_RET: begin
						ctrl.pc_en  = 1'b0;
						end_run     = 1'b1;
						accept_next = (insn.opcode[4:3] == RVAL_A) ? !a_zero : |insn.k;
						state_next  = S_DONE;
					end
					CLS_MISC: begin
						if (insn.opcode[7] == MISC_TXA) begin
							ctrl.a_sel = A_X;
							ctrl.a_en  = 1'b1;
						end else begin
							ctrl.x_sel = X_A; // TAX
							ctrl.x_en  = 1'b1;
						end
					end
					default: ; // Store classes not built, step over
				endcase
			end
			S_LOAD_WAIT: begin
				ctrl.a_sel = A_PKT; // pkt_q valid now
				ctrl.a_en  = 1'b1;
				ctrl.pc_en = 1'b1;
				state_next = S_FETCH;
			end
			default: begin
				state_next = S_IDLE; // Done strobe lasts one cycle
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= S_IDLE;
			accept    <= 1'b0;
			ret_sel_a <= 1'b0;
		end else begin
			state <= state_next;
			if (end_run) begin
				accept    <= accept_next; // Stays low on oob
				ret_sel_a <= (insn.opcode[4:3] == RVAL_A);
			end
		end
	end

	assign busy = (state != S_IDLE); // Includes the done cycle
	assign done = (state == S_DONE);

endmodule

// ==== hdl/bpf_cpu.sv ====
`timescale 1ns/1ps
`include "bpf_params.svh"

module bpf_cpu import bpf_isa_pkg::*, bpf_core_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  logic [`BPF_LEN_W-1:0]   packet_len,
	input  bpf_insn_t               code_q,
	input  pkt_word_t               pkt_q,
	output logic                    code_rd_en,
	output logic [`BPF_CODE_AW-1:0] code_rd_addr,
	output logic                    pkt_rd_en,
	output logic [`BPF_PKT_WAW-1:0] pkt_rd_addr,
	output logic                    busy,
	output logic                    done,
	output logic                    accept,
	output logic [31:0]             ret_len
);

	ctrl_t       ctrl;
	flags_t      flags;
	bpf_insn_t   insn;
	logic        insn_ld;
	logic        ret_sel_a;
	logic [31:0] a;

	bpf_ctrl ctrl_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.insn       (insn),
		.flags      (flags),
		.a_zero     (a == 32'd0),
		.ctrl       (ctrl),
		.insn_ld    (insn_ld),
		.code_rd_en (code_rd_en),
		.pkt_rd_en  (pkt_rd_en),
		.busy       (busy),
		.done       (done),
		.accept     (accept),
		.ret_sel_a  (ret_sel_a)
	);

	bpf_datapath datapath_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.ctrl        (ctrl),
		.insn_ld     (insn_ld),
		.code_q      (code_q),
		.pkt_q       (pkt_q),
		.packet_len  (packet_len),
		.insn        (insn),
		.pc          (code_rd_addr), // Fetch address is PC itself
		.pkt_rd_addr (pkt_rd_addr),
		.flags       (flags),
		.a           (a)
	);

	// Reject, out-of-bounds load included, returns 0
	assign ret_len = accept ? (ret_sel_a ? a : insn.k) : '0;

endmodule

// ==== hdl/bpf_filter.sv ====
`timescale 1ns/1ps
`include "bpf_params.svh"

module bpf_filter import bpf_isa_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    code_wr,
	input  logic [`BPF_CODE_AW-1:0] code_addr,
	input  bpf_insn_t               code_data,
	input  logic                    pkt_wr,
	input  logic [`BPF_PKT_WAW-1:0] pkt_addr,
	input  pkt_word_t               pkt_data,
	input  logic [`BPF_LEN_W-1:0]   packet_len,
	input  logic                    start,
	output logic                    busy,
	output logic                    done,
	output logic                    accept,
	output logic [31:0]             ret_len
);

	logic                    code_rd_en;
	logic [`BPF_CODE_AW-1:0] code_rd_addr;
	bpf_insn_t               code_q;
	logic                    pkt_rd_en;
	logic [`BPF_PKT_WAW-1:0] pkt_rd_addr;
	pkt_word_t               pkt_q;

	bpf_cpu cpu_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start),
		.packet_len   (packet_len),
		.code_q       (code_q),
		.pkt_q        (pkt_q),
		.code_rd_en   (code_rd_en),
		.code_rd_addr (code_rd_addr),
		.pkt_rd_en    (pkt_rd_en),
		.pkt_rd_addr  (pkt_rd_addr),
		.busy         (busy),
		.done         (done),
		.accept       (accept),
		.ret_len      (ret_len)
	);

	bpf_mem #(
		.word_t (bpf_insn_t),
		.AW     (`BPF_CODE_AW)
	) code_mem_i ( // Program store
		.clk     (clk),
		.wr      (code_wr),
		.wr_addr (code_addr),
		.wr_data (code_data),
		.rd_en   (code_rd_en),
		.rd_addr (code_rd_addr),
		.rd_data (code_q)
	);

	bpf_mem #(
		.word_t (pkt_word_t),
		.AW     (`BPF_PKT_WAW)
	) pkt_mem_i ( // Packet buffer, word addressed
		.clk     (clk),
		.wr      (pkt_wr),
		.wr_addr (pkt_addr),
		.wr_data (pkt_data),
		.rd_en   (pkt_rd_en),
		.rd_addr (pkt_rd_addr),
		.rd_data (pkt_q)
	);

endmodule

// ==== dv/bpf_filter_tb.sv ====
`timescale 1ns/1ps
`include "bpf_params.svh"

module bpf_filter_tb import bpf_isa_pkg::*; ();

	localparam int NUM_ROWS    = 20;
	localparam int PKT_BYTES   = 64; // Bytes written before each run
	localparam int WATCHDOG_NS = NUM_ROWS * 256 * 4 * 10; // 256 insns at 4 cycles per row

	localparam int P_ETH = 0; // Ethertype filter
	localparam int P_ALU = 1; // ALU chain
	localparam int P_IND = 2; // Indirect byte load through TAX/TXA
	localparam int P_LEN = 3; // Length compares and jumps
	localparam int P_BND = 4; // Load past the packet end

	localparam logic [31:0] ADD_K = 32'h1234_5678;
	localparam logic [31:0] AND_X = 32'h0ff0_f0ff; // Loaded into X by LDX
	localparam logic [31:0] LSH_K = 32'd3;
	localparam logic [31:0] SUB_K = 32'h0000_0100;

	typedef struct packed {
		logic [2:0]  prog;
		logic        rand_pkt; // Packet bytes from the LCG
		logic [11:0] len;
		logic        restart; // Second start pulse while busy
		logic        exp_acc; // Fixed rows only
		logic [31:0] exp_ret;
	} row_t;

	logic                    clk;
	logic                    arst_n;
	logic                    code_wr;
	logic [`BPF_CODE_AW-1:0] code_addr;
	bpf_insn_t               code_data;
	logic                    pkt_wr;
	logic [`BPF_PKT_WAW-1:0] pkt_addr;
	pkt_word_t               pkt_data;
	logic [`BPF_LEN_W-1:0]   packet_len;
	logic                    start;
	logic                    busy;
	logic                    done;
	logic                    accept;
	logic [31:0]             ret_len;

	logic [31:0] lcg_state = 32'h817b_8d19;
	logic [7:0]  pkt_bytes [PKT_BYTES]; // Big-endian image of the packet
	row_t        rows [NUM_ROWS];
	int          done_cnt = 0;
	int          errors = 0;

	bpf_filter bpf_filter_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.code_wr    (code_wr),
		.code_addr  (code_addr),
		.code_data  (code_data),
		.pkt_wr     (pkt_wr),
		.pkt_addr   (pkt_addr),
		.pkt_data   (pkt_data),
		.packet_len (packet_len),
		.start      (start),
		.busy       (busy),
		.done       (done),
		.accept     (accept),
		.ret_len    (ret_len)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	always @(posedge clk) begin
		if (done) begin
			done_cnt <= done_cnt + 1; // Counts stray strobes too
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out before all rows finished");
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic bpf_insn_t encode(input int op, input int jt, input int jf,
			input logic [31:0] k);
		bpf_insn_t i;
		i.opcode = 16'(op);
		i.jt     = 8'(jt);
		i.jf     = 8'(jf);
		i.k      = k;
		return i;
	endfunction

	function automatic row_t make_row(input int prog, input int rnd, input int len,
			input int restart, input int acc, input logic [31:0] ret);
		row_t r;
		r.prog     = 3'(prog);
		r.rand_pkt = 1'(rnd);
		r.len      = 12'(len);
		r.restart  = 1'(restart);
		r.exp_acc  = 1'(acc);
		r.exp_ret  = ret;
		return r;
	endfunction

	task automatic write_program(input int prog);
		bpf_insn_t code [$];
		case (prog)
			P_ETH: code = '{encode('h28, 0, 0, 12), encode('h15, 0, 1, 32'h0800), // ldh [12] then jeq
				encode('h06, 0, 0, 32'hffff), encode('h06, 0, 0, 0)};
			P_ALU: code = '{encode('h20, 0, 0, 0), encode('h04, 0, 0, ADD_K),
				encode('h01, 0, 0, AND_X), encode('h5c, 0, 0, 0), encode('h64, 0, 0, LSH_K),
				encode('h14, 0, 0, SUB_K), encode('h16, 0, 0, 0)}; // Ends in ret a
			P_IND: code = '{encode('h01, 0, 0, 5), encode('h50, 0, 0, 3), encode('h07, 0, 0, 0),
				encode('h00, 0, 0, 0), encode('h87, 0, 0, 0), encode('h16, 0, 0, 0)};
			P_LEN: code = '{encode('h80, 0, 0, 0), encode('h01, 0, 0, 100),
				encode('h2d, 0, 3, 0), encode('h45, 0, 1, 1), // jgt x then jset #1
				encode('h06, 0, 0, 32'h111), encode('h06, 0, 0, 32'h222),
				encode('h35, 0, 1, 40), encode('h06, 0, 0, 32'h333),
				encode('h05, 0, 0, 1), encode('h06, 0, 0, 0), // ja skips the ret #0
				encode('h06, 0, 0, 32'h444)};
			default: code = '{encode('h20, 0, 0, 16), encode('h28, 0, 0, 19),
				encode('h06, 0, 0, 32'h5555)};
		endcase
		for (int i = 0; i < code.size(); i++) begin
			@(negedge clk);
			code_wr   = 1'b1;
			code_addr = `BPF_CODE_AW'(i);
			code_data = code[i];
		end
		@(negedge clk);
		code_wr = 1'b0;
	endtask

	task automatic fill_packet(input row_t r);
		logic [31:0] rnd;
		for (int i = 0; i < PKT_BYTES; i++) begin
			rnd          = r.rand_pkt ? lcg_next() : 32'(i * 37) << 24;
			pkt_bytes[i] = rnd[31:24];
		end
		if (r.rand_pkt && r.prog == P_ETH) begin
			rnd = lcg_next();
			if (rnd[20]) begin
				pkt_bytes[12] = 8'h08; // IPv4 ethertype on about half the packets
				pkt_bytes[13] = 8'h00;
			end
		end
	endtask

	task automatic write_packet();
		for (int i = 0; i < PKT_BYTES / 4; i++) begin
			@(negedge clk);
			pkt_wr   = 1'b1;
			pkt_addr = `BPF_PKT_WAW'(i);
			pkt_data = {pkt_bytes[4*i], pkt_bytes[4*i+1], pkt_bytes[4*i+2], pkt_bytes[4*i+3]};
		end
		@(negedge clk);
		pkt_wr = 1'b0;
	endtask

	task automatic compute_expected(input row_t r, output logic acc, output logic [31:0] ret);
		logic [31:0] v;
		acc = r.exp_acc;
		ret = r.exp_ret;
		if (r.rand_pkt) begin
			case (r.prog)
				P_ETH: begin
					acc = ({pkt_bytes[12], pkt_bytes[13]} == 16'h0800);
					ret = acc ? 32'h0000_ffff : 32'h0;
				end
				P_ALU: begin
					v   = {pkt_bytes[0], pkt_bytes[1], pkt_bytes[2], pkt_bytes[3]};
					v   = ((v + ADD_K) & AND_X) << LSH_K; // Wraps modulo 2**32
					v   = v - SUB_K;
					acc = (v != 32'h0);
					ret = v;
				end
				default: begin
					v   = 32'(pkt_bytes[8]); // X of 5 plus k of 3
					acc = (v != 32'h0);
					ret = v;
				end
			endcase
		end
	endtask

	initial begin
		row_t        cur;
		logic        exp_acc;
		logic [31:0] exp_ret;
		logic        got_acc;
		logic [31:0] got_ret;
		int          row_errs;
		int          dones_before;
		int          passed;
		int          failed;

		arst_n     = 1'b0;
		code_wr    = 1'b0;
		code_addr  = '0;
		code_data  = '0;
		pkt_wr     = 1'b0;
		pkt_addr   = '0;
		pkt_data   = '0;
		packet_len = '0;
		start      = 1'b0;
		passed     = 0;
		failed     = 0;
		rows = '{
			make_row(P_ETH, 1, 60, 0, 0, 0), make_row(P_ETH, 1, 60, 0, 0, 0),
			make_row(P_ETH, 1, 60, 0, 0, 0), make_row(P_ETH, 1, 60, 0, 0, 0),
			make_row(P_ETH, 1, 60, 0, 0, 0), make_row(P_ETH, 1, 60, 0, 0, 0),
			make_row(P_ETH, 1, 60, 0, 0, 0), make_row(P_ETH, 1, 60, 0, 0, 0),
			make_row(P_ALU, 1, 16, 0, 0, 0), make_row(P_ALU, 1, 16, 0, 0, 0),
			make_row(P_IND, 1, 16, 0, 0, 0), make_row(P_IND, 1, 16, 0, 0, 0),
			make_row(P_LEN, 0, 120, 0, 1, 32'h222), // Above 100 and even
			make_row(P_LEN, 0, 101, 0, 1, 32'h111), // Above 100 and odd
			make_row(P_LEN, 0, 100, 0, 1, 32'h333),
			make_row(P_LEN, 0, 40, 0, 1, 32'h333),
			make_row(P_LEN, 0, 39, 0, 1, 32'h444),
			make_row(P_BND, 0, 20, 0, 0, 32'h0), // ldh [19] reaches byte 20
			make_row(P_BND, 0, 21, 0, 1, 32'h5555),
			make_row(P_ALU, 1, 16, 1, 0, 0)
		};

		repeat (10) @(negedge clk);
		arst_n = 1'b1;
		if (busy || done) begin
			$display("busy or done is high right after reset");
			errors++;
		end

		for (int r = 0; r < NUM_ROWS; r++) begin
			cur      = rows[r];
			row_errs = 0;
			fill_packet(cur);
			write_program(int'(cur.prog));
			write_packet();
			compute_expected(cur, exp_acc, exp_ret);

			@(negedge clk);
			packet_len   = cur.len;
			start        = 1'b1;
			dones_before = done_cnt;
			@(negedge clk);
			start = 1'b0;
			if (!busy) begin
				$display("row %0d: busy did not rise after start", r);
				row_errs++;
			end
			if (cur.restart) begin
				repeat (3) @(negedge clk);
				start = 1'b1; // Core is mid-run here
				@(negedge clk);
				start = 1'b0;
			end

			while (!done) begin
				@(negedge clk);
			end
			got_acc = accept;
			got_ret = ret_len;
			if (got_acc !== exp_acc) begin
				$display("FAIL row %0d accept: got %h, expected %h", r, got_acc, exp_acc);
				row_errs++;
			end
			if (got_ret !== exp_ret) begin
				$display("FAIL row %0d ret_len: got %h, expected %h", r, got_ret, exp_ret);
				row_errs++;
			end

			repeat (40) @(negedge clk); // Long enough for a stray second run to finish
			if (done_cnt - dones_before != 1) begin
				$display("row %0d: expected one done strobe but saw %0d", r,
					done_cnt - dones_before);
				row_errs++;
			end

			errors += row_errs;
			if (row_errs == 0) begin
				passed++;
			end else begin
				failed++;
			end
			$display("row %0d prog %0d len %0d restart %0d: %s", r, cur.prog, cur.len,
				cur.restart, (row_errs == 0) ? "pass" : "fail");
		end

		$display("rows %0d, passed %0d, failed %0d, errors %0d", NUM_ROWS, passed, failed,
			errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/bpf_isa_pkg.sv
hdl/bpf_core_pkg.sv
hdl/bpf_mem.sv
hdl/bpf_alu.sv
hdl/bpf_datapath.sv
hdl/bpf_ctrl.sv
hdl/bpf_cpu.sv
hdl/bpf_filter.sv
dv/bpf_filter_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module bpf_filter_tb -f project.f -o bpf_sim || exit 1
out=$(./obj_dir/bpf_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
